// ==== Makefile ====
TOP = eth_frame_loop_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== source/eth_frame_loop.sv ====
// Single clock; the receive stream has no ready, so a full buffer only discards whole frames
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop
(
	input logic clk,
	input logic reset,

	input logic [eth_loop_pkg::C_NUM_SCRIPTS-1:0] script_en,
	output logic [31:0] overflow_count,

	input logic mem_req,
	input logic [eth_loop_pkg::C_MEM_ADDR_WIDTH-1:0] mem_addr,
	input logic mem_wenable,
	input logic [31:0] mem_wdata,
	output logic [31:0] mem_rdata,
	output logic mem_ack,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready,

	input logic [7:0] s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid
);
	eth_loop_pkg::script_cfg_t [eth_loop_pkg::C_NUM_SCRIPTS-1:0] cfg;
	eth_loop_pkg::loop_beat_t cmp_beat, edit_beat;
	logic cmp_valid, edit_valid;
	eth_loop_pkg::frame_desc_t desc;
	logic desc_valid, desc_ready;
	eth_loop_pkg::buf_entry_t buf_byte;
	logic buf_valid, buf_ready;

	eth_frame_loop_mem U0
	(
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.cfg(cfg)
	);

	eth_frame_loop_compare U1
	(
		.clk(clk),
		.reset(reset),
		.script_en(script_en),
		.cfg(cfg),
		.in_data(s_axis_tdata),
		.in_last(s_axis_tlast),
		.in_err(s_axis_tuser),
		.in_valid(s_axis_tvalid),
		.out_beat(cmp_beat),
		.out_valid(cmp_valid)
	);

	eth_frame_loop_edit U2
	(
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.in_beat(cmp_beat),
		.in_valid(cmp_valid),
		.out_beat(edit_beat),
		.out_valid(edit_valid)
	);

	eth_frame_loop_fifo U3
	(
		.clk(clk),
		.reset(reset),
		.in_beat(edit_beat),
		.in_valid(edit_valid),
		.desc(desc),
		.desc_valid(desc_valid),
		.desc_ready(desc_ready),
		.byte_out(buf_byte),
		.byte_valid(buf_valid),
		.byte_ready(buf_ready),
		.overflow_count(overflow_count)
	);

	eth_frame_loop_tx U4
	(
		.clk(clk),
		.reset(reset),
		.desc(desc),
		.desc_valid(desc_valid),
		.desc_ready(desc_ready),
		.byte_in(buf_byte),
		.byte_valid(buf_valid),
		.byte_ready(buf_ready),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);
endmodule

`default_nettype wire

// ==== source/eth_frame_loop_compare.sv ====
// Input is never stalled; match bits are zero on beats before offset 8, so short frames never match
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_compare
(
	input logic clk,
	input logic reset,

	input logic [eth_loop_pkg::C_NUM_SCRIPTS-1:0] script_en,
	input eth_loop_pkg::script_cfg_t [eth_loop_pkg::C_NUM_SCRIPTS-1:0] cfg,

	input logic [7:0] in_data,
	input logic in_last,
	input logic in_err,
	input logic in_valid,

	output eth_loop_pkg::loop_beat_t out_beat,
	output logic out_valid
);
	logic [7:0] offset;
	logic in_header;
	logic [eth_loop_pkg::C_MATCH_IDX_WIDTH-1:0] idx;
	logic [eth_loop_pkg::C_NUM_SCRIPTS-1:0] match_run, match_cur, match_next;

	always_comb begin
		in_header = offset < 8'(eth_loop_pkg::C_MATCH_BYTES);
		idx = offset[eth_loop_pkg::C_MATCH_IDX_WIDTH-1:0];
		// Every enabled script is a candidate at frame start
		match_cur = (offset == 8'd0) ? script_en : match_run;
		match_next = match_cur;
		for (int s = 0; s < eth_loop_pkg::C_NUM_SCRIPTS; s++) begin
			if (in_header && (((in_data ^ cfg[s].pattern[idx]) & cfg[s].mask[idx]) != 8'd0)) begin
				match_next[s] = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			offset <= 8'd0;
			match_run <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				match_run <= match_next;
				if (in_last) begin
					offset <= 8'd0;
				end else if (offset != 8'hff) begin
					offset <= offset + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		out_beat.data <= in_data;
		out_beat.last <= in_last;
		out_beat.err <= in_err && in_last;
		out_beat.offset <= offset;
		// Disabling a script mid-frame also cancels its match
		out_beat.match <= in_header ? '0 : (match_next & script_en);
	end
endmodule

`default_nettype wire

// ==== source/eth_frame_loop_edit.sv ====
// At most one byte is replaced per beat; an edit_offset below 8 never applies
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_edit
(
	input logic clk,
	input logic reset,

	input eth_loop_pkg::script_cfg_t [eth_loop_pkg::C_NUM_SCRIPTS-1:0] cfg,

	input eth_loop_pkg::loop_beat_t in_beat,
	input logic in_valid,

	output eth_loop_pkg::loop_beat_t out_beat,
	output logic out_valid
);
	logic past_header;
	eth_loop_pkg::loop_beat_t edited;

	always_comb begin
		past_header = in_beat.offset >= 8'(eth_loop_pkg::C_MATCH_BYTES);
		edited = in_beat;
		// Walk downwards so the lowest script is applied last
		for (int s = eth_loop_pkg::C_NUM_SCRIPTS - 1; s >= 0; s--) begin
			if (past_header && in_beat.match[s] && cfg[s].edit_en &&
				cfg[s].edit_offset == in_beat.offset) begin
				edited.data = cfg[s].edit_value;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_beat <= edited;
	end
endmodule

`default_nettype wire

// ==== source/eth_frame_loop_fifo.sv ====
// Frames are admitted only at their first byte; a frame longer than 64 bytes keeps 63 plus its last
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_fifo
(
	input logic clk,
	input logic reset,

	input eth_loop_pkg::loop_beat_t in_beat,
	input logic in_valid,

	output eth_loop_pkg::frame_desc_t desc,
	output logic desc_valid,
	input logic desc_ready,

	output eth_loop_pkg::buf_entry_t byte_out,
	output logic byte_valid,
	input logic byte_ready,

	output logic [31:0] overflow_count
);
	logic [$clog2(eth_loop_pkg::C_LOOP_FIFO_DEPTH+1)-1:0] byte_free;
	logic byte_empty, desc_empty, desc_full;
	logic first, room, accept, keep_byte;
	logic admitted, trunc;
	logic byte_wr_en, desc_wr_en;
	eth_loop_pkg::buf_entry_t byte_wr;
	eth_loop_pkg::frame_desc_t desc_wr;

	always_comb begin
		first = in_beat.offset == 8'd0;
		room = (byte_free >= eth_loop_pkg::C_MAX_FRAME) && !desc_full;
		accept = first ? room : admitted;
		// Last byte always stored so the reader finds the frame end
		keep_byte = in_beat.last || (in_beat.offset < 8'(eth_loop_pkg::C_MAX_FRAME - 1));
		byte_wr_en = in_valid && accept && keep_byte;
		byte_wr.data = in_beat.data;
		byte_wr.last = in_beat.last;
		desc_wr_en = in_valid && accept && in_beat.last;
		desc_wr.drop = in_beat.err || (trunc && !first);
		desc_wr.hit = |in_beat.match;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			admitted <= 1'b0;
			trunc <= 1'b0;
			overflow_count <= 32'd0;
		end else if (in_valid) begin
			if (first) begin
				admitted <= room;
				if (!room) begin
					overflow_count <= overflow_count + 32'd1;
				end
			end
			trunc <= (trunc && !first) || !keep_byte;
		end
	end

	loop_sync_fifo #(
		.payload_t(eth_loop_pkg::buf_entry_t),
		.DEPTH(eth_loop_pkg::C_LOOP_FIFO_DEPTH)
	) U0
	(
		.clk(clk),
		.reset(reset),
		.wr_en(byte_wr_en),
		.wr_data(byte_wr),
		.rd_en(byte_ready),
		.rd_data(byte_out),
		.empty(byte_empty),
		.full(),
		.free_count(byte_free)
	);

	loop_sync_fifo #(
		.payload_t(eth_loop_pkg::frame_desc_t),
		.DEPTH(eth_loop_pkg::C_CTL_FIFO_DEPTH)
	) U1
	(
		.clk(clk),
		.reset(reset),
		.wr_en(desc_wr_en),
		.wr_data(desc_wr),
		.rd_en(desc_ready),
		.rd_data(desc),
		.empty(desc_empty),
		.full(desc_full),
		.free_count()
	);

	assign byte_valid = !byte_empty;
	assign desc_valid = !desc_empty;
endmodule

`default_nettype wire

// ==== source/eth_frame_loop_mem.sv ====
// One request per acknowledge; words 5 to 7 of each script slot ignore writes and read as zero
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_mem
(
	input logic clk,
	input logic reset,

	input logic mem_req,
	input logic [eth_loop_pkg::C_MEM_ADDR_WIDTH-1:0] mem_addr,
	input logic mem_wenable,
	input logic [31:0] mem_wdata,
	output logic [31:0] mem_rdata,
	output logic mem_ack,

	output eth_loop_pkg::script_cfg_t [eth_loop_pkg::C_NUM_SCRIPTS-1:0] cfg
);
	logic [eth_loop_pkg::C_MEM_ADDR_WIDTH-eth_loop_pkg::C_MEM_SLOT_BITS-1:0] sel_script;
	logic [eth_loop_pkg::C_MEM_SLOT_BITS-1:0] sel_word;
	logic word_stored;
	logic [31:0] words [eth_loop_pkg::C_NUM_SCRIPTS][eth_loop_pkg::C_CFG_WORDS];

	always_comb begin
		sel_script = mem_addr[eth_loop_pkg::C_MEM_ADDR_WIDTH-1:eth_loop_pkg::C_MEM_SLOT_BITS];
		sel_word = mem_addr[eth_loop_pkg::C_MEM_SLOT_BITS-1:0];
		word_stored = sel_word < eth_loop_pkg::C_MEM_SLOT_BITS'(eth_loop_pkg::C_CFG_WORDS);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			for (int s = 0; s < eth_loop_pkg::C_NUM_SCRIPTS; s++) begin
				for (int w = 0; w < eth_loop_pkg::C_CFG_WORDS; w++) begin
					words[s][w] <= '0;
				end
			end
		end else begin
			mem_ack <= mem_req;
			if (mem_req && mem_wenable && word_stored) begin
				words[sel_script][sel_word] <= mem_wdata;
			end
		end
	end

	// Old contents are returned on a write
	always_ff @(posedge clk) begin
		mem_rdata <= word_stored ? words[sel_script][sel_word] : 32'd0;
	end

	always_comb begin
		for (int s = 0; s < eth_loop_pkg::C_NUM_SCRIPTS; s++) begin
			cfg[s].pattern = {words[s][1], words[s][0]};
			cfg[s].mask = {words[s][3], words[s][2]};
			cfg[s].edit_offset = words[s][4][7:0];
			cfg[s].edit_value = words[s][4][15:8];
			cfg[s].edit_en = words[s][4][16];
		end
	end
endmodule

`default_nettype wire

// ==== source/eth_frame_loop_tx.sv ====
// One idle cycle between frames; dropped frames drain at one byte per cycle
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_tx
(
	input logic clk,
	input logic reset,

	input eth_loop_pkg::frame_desc_t desc,
	input logic desc_valid,
	output logic desc_ready,

	input eth_loop_pkg::buf_entry_t byte_in,
	input logic byte_valid,
	output logic byte_ready,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_DRAIN} tx_state_t;

	tx_state_t state;
	logic hit;

	always_comb begin
		desc_ready = state == ST_IDLE;
		m_axis_tdata = byte_in.data;
		m_axis_tlast = byte_in.last;
		m_axis_tuser = hit && byte_in.last;
		m_axis_tvalid = (state == ST_SEND) && byte_valid;
		byte_ready = (state == ST_DRAIN) || ((state == ST_SEND) && m_axis_tready);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (desc_valid) begin
						state <= desc.drop ? ST_DRAIN : ST_SEND;
					end
				end
				ST_SEND: begin
					if (byte_valid && m_axis_tready && byte_in.last) begin
						state <= ST_IDLE;
					end
				end
				ST_DRAIN: begin
					if (byte_valid && byte_in.last) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && desc_valid) begin
			hit <= desc.hit;
		end
	end
endmodule

`default_nettype wire

// ==== source/eth_loop_pkg.sv ====
// Sizes are fixed at four scripts, an 8-byte header match and 8-bit stream bytes
`default_nettype none

package eth_loop_pkg;

	localparam int C_NUM_SCRIPTS = 4;
	localparam int C_MATCH_BYTES = 8;
	localparam int C_MATCH_IDX_WIDTH = $clog2(C_MATCH_BYTES);
	localparam int C_MAX_FRAME = 64;
	localparam int C_LOOP_FIFO_DEPTH = 256;
	localparam int C_CTL_FIFO_DEPTH = 8;

	// Script s, word w at address s*8+w
	localparam int C_MEM_ADDR_WIDTH = 5;
	localparam int C_MEM_SLOT_BITS = 3;
	localparam int C_CFG_WORDS = 5;

	typedef struct packed {
		logic [C_MATCH_BYTES-1:0][7:0] pattern;
		logic [C_MATCH_BYTES-1:0][7:0] mask;
		logic [7:0] edit_offset;
		logic [7:0] edit_value;
		logic edit_en;
	} script_cfg_t;

	// offset saturates at 255
	typedef struct packed {
		logic [7:0] data;
		logic last;
		logic err;
		logic [7:0] offset;
		logic [C_NUM_SCRIPTS-1:0] match;
	} loop_beat_t;

	typedef struct packed {
		logic drop;
		logic hit;
	} frame_desc_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} buf_entry_t;

endpackage

`default_nettype wire

// ==== source/loop_sync_fifo.sv ====
// DEPTH must be a power of two; writes when full and reads when empty are ignored
`default_nettype none
`timescale 1ns/1ps

module loop_sync_fifo
#(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
)
(
	input logic clk,
	input logic reset,

	input logic wr_en,
	input payload_t wr_data,

	input logic rd_en,
	output payload_t rd_data,

	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] free_count
);
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;
	logic do_wr, do_rd;

	always_comb begin
		empty = count == CW'(0);
		full = count == CW'(DEPTH);
		free_count = CW'(DEPTH) - count;
		do_wr = wr_en && !full;
		do_rd = rd_en && !empty;
		// Head is visible without a read request
		rd_data = mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end
endmodule

`default_nettype wire

// ==== src.f ====
source/eth_loop_pkg.sv
source/loop_sync_fifo.sv
source/eth_frame_loop_mem.sv
source/eth_frame_loop_compare.sv
source/eth_frame_loop_edit.sv
source/eth_frame_loop_fifo.sv
source/eth_frame_loop_tx.sv
source/eth_frame_loop.sv
testbench/eth_frame_loop_props.sv
testbench/eth_frame_loop_tb.sv

// ==== testbench/eth_frame_loop_props.sv ====
// Bound to every eth_frame_loop instance; reset checks look one cycle after a reset edge
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_props (
	input logic clk,
	input logic reset,
	input logic mem_req,
	input logic mem_ack,
	input logic [7:0] m_axis_tdata,
	input logic m_axis_tlast,
	input logic m_axis_tvalid,
	input logic m_axis_tready
);
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		mem_req |=> mem_ack)
		else $error("mem_ack did not follow mem_req by one cycle");

	ack_only_for_req: assert property (@(posedge clk) disable iff (reset)
		!mem_req |=> !mem_ack)
		else $error("mem_ack without a request in the cycle before");

	// Stalled beat keeps its data and stays valid
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		m_axis_tvalid && !m_axis_tready |=>
		m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
		else $error("transmit beat changed while stalled");

	quiet_in_reset: assert property (@(posedge clk)
		reset |=> !m_axis_tvalid && !mem_ack)
		else $error("m_axis_tvalid or mem_ack high after a reset cycle");
endmodule

bind eth_frame_loop eth_frame_loop_props props_i (
	.clk(clk),
	.reset(reset),
	.mem_req(mem_req),
	.mem_ack(mem_ack),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tlast(m_axis_tlast),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready)
);

`default_nettype wire

// ==== testbench/eth_frame_loop_tb.sv ====
// Run from the project root; stimulus, expected frames and the cycle limit all come from the case file
`default_nettype none
`timescale 1ns/1ps

module eth_frame_loop_tb;
	localparam string CASE_FILE = "testbench/loop_cases.txt";

	typedef struct packed {
		logic [15:0] len;
		logic user;
	} frame_info_t;

	logic clk;
	logic reset;
	logic [eth_loop_pkg::C_NUM_SCRIPTS-1:0] script_en;
	logic [31:0] overflow_count;
	logic mem_req;
	logic [eth_loop_pkg::C_MEM_ADDR_WIDTH-1:0] mem_addr;
	logic mem_wenable;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic mem_ack;
	logic [7:0] m_axis_tdata;
	logic m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready = 1'b0;
	logic [7:0] s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;

	logic hold_ready;
	logic input_busy;
	int cycle_count = 0;
	int cycle_limit = 0;
	int rx_len = 0;
	string lines[$];
	logic [7:0] hdr [8];
	logic [7:0] rx_bytes[$];
	logic [7:0] exp_bytes[$];
	frame_info_t rx_frames[$];
	frame_info_t exp_frames[$];
	frame_info_t got_info;

	eth_frame_loop eth_frame_loop_i (
		.clk(clk),
		.reset(reset),
		.script_en(script_en),
		.overflow_count(overflow_count),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// Roughly three beats in four are accepted
	initial begin
		void'($urandom(32'hf552));
		forever begin
			@(posedge clk);
			m_axis_tready <= !hold_ready && (($urandom() & 32'd3) != 32'd0);
		end
	end

	always @(posedge clk) begin
		if (!reset && m_axis_tvalid && m_axis_tready) begin
			rx_bytes.push_back(m_axis_tdata);
			rx_len = rx_len + 1;
			if (m_axis_tlast) begin
				got_info.len = 16'(rx_len);
				got_info.user = m_axis_tuser;
				rx_frames.push_back(got_info);
				rx_len = 0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail %s: got %h, expected %h", name, got, expected);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// Header bytes from the case line, the rest follow the offset
	function automatic logic [7:0] frame_byte(input int i);
		return (i < 8) ? hdr[i] : (8'(i) ^ 8'h5a);
	endfunction

	task automatic end_input();
		if (input_busy) begin
			@(posedge clk);
			s_axis_tvalid <= 1'b0;
			s_axis_tlast <= 1'b0;
			s_axis_tuser <= 1'b0;
			input_busy = 1'b0;
		end
	endtask

	task automatic mem_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] rdata);
		@(posedge clk);
		mem_req <= 1'b1;
		mem_addr <= addr[eth_loop_pkg::C_MEM_ADDR_WIDTH-1:0];
		mem_wenable <= wr;
		mem_wdata <= data;
		@(posedge clk);
		mem_req <= 1'b0;
		mem_wenable <= 1'b0;
		do begin
			@(posedge clk);
		end while (!mem_ack);
		rdata = mem_rdata;
	endtask

	task automatic send_frame(input int len, input logic err);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			s_axis_tvalid <= 1'b1;
			s_axis_tdata <= frame_byte(i);
			s_axis_tlast <= (i == len - 1);
			s_axis_tuser <= err && (i == len - 1);
		end
		input_busy = 1'b1;
	endtask

	task automatic record_expected(input int len, input logic user, input int pos,
		input logic [7:0] value);
		frame_info_t info;
		info.len = 16'(len);
		info.user = user;
		exp_frames.push_back(info);
		for (int i = 0; i < len; i++) begin
			exp_bytes.push_back((pos != 0 && i == pos) ? value : frame_byte(i));
		end
	endtask

	task automatic compare_frames();
		frame_info_t got;
		frame_info_t want;
		while (rx_frames.size() < exp_frames.size()) begin
			@(posedge clk);
		end
		check_value("frame count", rx_frames.size(), exp_frames.size());
		while (exp_frames.size() > 0) begin
			got = rx_frames.pop_front();
			want = exp_frames.pop_front();
			check_value("frame length at m_axis_tlast", got.len, want.len);
			check_value("m_axis_tuser", got.user, want.user);
			for (int i = 0; i < want.len; i++) begin
				check_value("m_axis_tdata", rx_bytes.pop_front(), exp_bytes.pop_front());
			end
		end
	endtask

	// A discarded frame must never show up, even behind a drained one
	task automatic expect_idle_output();
		repeat (2 * eth_loop_pkg::C_MAX_FRAME) begin
			@(posedge clk);
			check_value("m_axis_tvalid", m_axis_tvalid, 32'd0);
		end
		check_value("frame count", rx_frames.size(), 32'd0);
	endtask

	initial begin
		int fd;
		int n;
		int len;
		int flag;
		int pos;
		int total_bytes;
		logic [7:0] kind;
		logic [7:0] value;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] rdata;
		logic [31:0] words [5];
		string line;

		reset = 1'b1;
		script_en = '0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_wenable = 1'b0;
		mem_wdata = '0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		hold_ready = 1'b0;
		input_busy = 1'b0;

		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			stop_with_error("Could not open the case file");
		end
		total_bytes = 0;
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				lines.push_back(line);
				if (line.getc(0) == "I" && $sscanf(line, "I %d", len) == 1) begin
					total_bytes += len;
				end
			end
		end
		$fclose(fd);
		cycle_limit = total_bytes * 200 + 5000;

		repeat (10) @(posedge clk);
		reset <= 1'b0;

		foreach (lines[k]) begin
			line = lines[k];
			kind = line.getc(0);
			n = 0;
			if (kind != "I") begin
				end_input();
			end
			case (kind)
				"W": begin
					n = $sscanf(line, "W %h %h %h %h %h %h", addr, words[0], words[1],
						words[2], words[3], words[4]);
					for (int w = 0; w < 5 && n == 6; w++) begin
						mem_access(1'b1, addr + w, words[w], rdata);
					end
					n = (n == 6) ? 1 : 0;
				end
				"R": begin
					n = $sscanf(line, "R %h %h", addr, data);
					mem_access(1'b0, addr, 32'd0, rdata);
					check_value("mem_rdata", rdata, data);
				end
				"E": begin
					n = $sscanf(line, "E %h", data);
					@(posedge clk);
					script_en <= data[eth_loop_pkg::C_NUM_SCRIPTS-1:0];
				end
				"T": begin
					n = $sscanf(line, "T %d", flag);
					hold_ready <= (flag != 0);
				end
				"I": begin
					n = $sscanf(line, "I %d %d %h %h %h %h %h %h %h %h", len, flag,
						hdr[0], hdr[1], hdr[2], hdr[3], hdr[4], hdr[5], hdr[6], hdr[7]);
					send_frame(len, flag != 0);
				end
				"O": begin
					n = $sscanf(line, "O %d %d %d %h %h %h %h %h %h %h %h %h", len, flag,
						pos, value, hdr[0], hdr[1], hdr[2], hdr[3], hdr[4], hdr[5],
						hdr[6], hdr[7]);
					record_expected(len, flag != 0, pos, value);
				end
				"S": begin
					n = 1;
					hold_ready <= 1'b0;
					compare_frames();
				end
				"C": begin
					n = $sscanf(line, "C %d", data);
					// Compare and edit stages plus the counter register
					repeat (3) @(posedge clk);
					check_value("overflow_count", overflow_count, data);
				end
				default: begin
					stop_with_error($sformatf("Unknown line in the case file: %s", line));
				end
			endcase
			if (n == 0) begin
				stop_with_error($sformatf("Malformed line in the case file: %s", line));
			end
		end

		end_input();
		hold_ready <= 1'b0;
		compare_frames();
		expect_idle_output();
		$display("TEST PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== testbench/loop_cases.txt ====
# W base w0 w1 w2 w3 w4: write five words from base (hex); R addr data: read, expect data (hex)
# E en: script_en (hex); T 1: hold tready low; S: wait for and compare expected frames
# I len err h0..h7: input frame; bytes from offset 8 on are offset xor 5a
# O len tuser pos val h0..h7: expected frame, byte pos becomes val (pos 0: none); C n: overflow_count
W 00 00000002 00000100 ffffffff 0000ffff 0001ee0a
W 08 00000002 00000000 000000ff 00000000 0001550a
W 10 00000000 06080000 00000000 ffff0000 00019904
W 1b 00000000 00000000 deadbeef 12345678 ffffffff
R 00 00000002
R 04 0001ee0a
R 0b 00000000
R 13 ffff0000
R 14 00019904
R 1c 00000000
R 1d 00000000
R 1f 00000000
# No match, two matches, short frame, match with an edit offset below 8
E 7
I 12 0 00 11 22 33 44 55 66 77
I 20 0 02 00 00 00 00 01 aa bb
I 6 0 02 00 00 00 00 01 00 00
I 16 0 10 20 30 40 50 60 08 06
O 12 0 0 00 00 11 22 33 44 55 66 77
O 20 1 10 ee 02 00 00 00 00 01 aa bb
O 6 0 0 00 02 00 00 00 00 01 00 00
O 16 1 0 00 10 20 30 40 50 60 08 06
S
# Script 0 disabled, then all disabled
E 6
I 20 0 02 00 00 00 00 01 aa bb
E 0
I 20 0 02 00 00 00 00 01 aa bb
O 20 1 10 55 02 00 00 00 00 01 aa bb
O 20 0 0 00 02 00 00 00 00 01 aa bb
S
# Error frame and long frame are dropped
E 7
I 10 1 00 11 22 33 44 55 66 77
I 70 0 00 11 22 33 44 55 66 77
I 9 0 02 00 00 00 00 01 aa bb
O 9 1 0 00 02 00 00 00 00 01 aa bb
S
C 0
# Buffer full under back-pressure
T 1
I 64 0 41 00 00 00 00 00 00 00
I 64 0 42 00 00 00 00 00 00 00
I 64 0 43 00 00 00 00 00 00 00
I 64 0 44 00 00 00 00 00 00 00
I 64 0 45 00 00 00 00 00 00 00
I 64 0 46 00 00 00 00 00 00 00
O 64 0 0 00 41 00 00 00 00 00 00 00
O 64 0 0 00 42 00 00 00 00 00 00 00
O 64 0 0 00 43 00 00 00 00 00 00 00
O 64 0 0 00 44 00 00 00 00 00 00 00
S
C 2
